// ==== list.f ====
src/gpio_pkg.sv
src/gpio_req_if.sv
src/gpio_bus_decode.sv
src/gpio_state_core.sv
src/gpio_tmr_voter.sv
src/gpio_tmr_top.sv
tests/tb_gpio_tmr.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_gpio_tmr
FILELIST = list.f
OBJDIR   = obj_dir
BIN      = $(OBJDIR)/V$(TOP)

.PHONY: all compile run clean

all: run

# build the simulation executable
compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# exit status of the executable is the test result
run: compile
	./$(BIN)

clean:
	rm -rf $(OBJDIR)

// ==== tests/tb_gpio_tmr.sv ====
`timescale 1ns/1ps

module tb_gpio_tmr import gpio_pkg::*; ();

	localparam int BUS_TIMEOUT = 16;
	localparam int INT_TIMEOUT = 32;

	// byte addresses of the registers
	localparam bus_addr_t A_IN    = 8'h00;
	localparam bus_addr_t A_OUT   = 8'h04;
	localparam bus_addr_t A_OE    = 8'h08;
	localparam bus_addr_t A_INTE  = 8'h0C;
	localparam bus_addr_t A_PTRIG = 8'h10;
	localparam bus_addr_t A_CTRL  = 8'h14;
	localparam bus_addr_t A_INTS  = 8'h18;
	localparam bus_addr_t A_ALIAS = 8'h1C;

	typedef enum logic [2:0] {OP_WR, OP_RD, OP_BAD, OP_PAD, OP_PINS, OP_INTA} op_e;

	typedef struct {
		op_e       op;
		bus_addr_t adr;
		byte_sel_t sel;
		bus_data_t data;
		gpio_vec_t pad;
		bus_data_t exp;
	} step_t;

	logic      wb_clk_in;
	logic      wb_rst_in;
	logic      wb_cyc_i;
	logic      wb_stb_i;
	logic      wb_we_i;
	bus_addr_t wb_adr_i;
	byte_sel_t wb_sel_i;
	bus_data_t wb_dat_i;
	bus_data_t wb_dat_o;
	logic      wb_ack_o;
	logic      wb_err_o;
	logic      wb_inta_o;
	gpio_vec_t gpio_pad_i;
	gpio_vec_t gpio_pad_o;
	gpio_vec_t gpio_oe_o;
	logic      tmr_err_o;

	step_t       table_q[$];
	logic [31:0] rnd = 32'h471c_8709;

	gpio_tmr_top DUT (.*);

	initial begin
		wb_clk_in = 1'b0;
		forever #5 wb_clk_in = ~wb_clk_in;
	end

	task automatic abort_run(input string why);
		$display("t=%0t %s", $time, why);
		$display("Something failed");
		$fatal(1, "run stopped");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
			abort_run("stopping at the first mismatch");
		end
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// one strobe cycle, returns whatever the slave answered with
	task automatic bus_access(input logic we, input bus_addr_t adr, input byte_sel_t sel,
		input bus_data_t wdat, output logic ack, output logic err, output bus_data_t rdat);
		int n;
		n = 0;
		@(posedge wb_clk_in);
		wb_cyc_i <= 1'b1;
		wb_stb_i <= 1'b1;
		wb_we_i  <= we;
		wb_adr_i <= adr;
		wb_sel_i <= sel;
		wb_dat_i <= wdat;
		@(negedge wb_clk_in);
		while (!wb_ack_o && !wb_err_o) begin
			n++;
			if (n > BUS_TIMEOUT)
				abort_run($sformatf("no ack or err for address %h", adr));
			@(negedge wb_clk_in);
		end
		ack  = wb_ack_o;
		err  = wb_err_o;
		rdat = wb_dat_o;
		@(posedge wb_clk_in);
		wb_cyc_i <= 1'b0;
		wb_stb_i <= 1'b0;
		wb_we_i  <= 1'b0;
	endtask

	task automatic bus_write(input bus_addr_t adr, input byte_sel_t sel, input bus_data_t data);
		logic      ack;
		logic      err;
		bus_data_t rd;
		bus_access(1'b1, adr, sel, data, ack, err, rd);
		check_value("wb_ack_o", 32'(ack), 32'd1);
		check_value("wb_err_o", 32'(err), 32'd0);
	endtask

	task automatic bus_read(input bus_addr_t adr, output bus_data_t data);
		logic ack;
		logic err;
		bus_access(1'b0, adr, 4'hF, '0, ack, err, data);
		check_value("wb_ack_o", 32'(ack), 32'd1);
		check_value("wb_err_o", 32'(err), 32'd0);
	endtask

	task automatic hold_pads(input gpio_vec_t pad);
		@(posedge wb_clk_in);
		gpio_pad_i <= pad;
		repeat (5) @(posedge wb_clk_in);
	endtask

	task automatic wait_inta(input logic level);
		int n;
		n = 0;
		@(negedge wb_clk_in);
		while (wb_inta_o !== level) begin
			n++;
			if (n > INT_TIMEOUT)
				abort_run($sformatf("wb_inta_o never went to %0b", level));
			@(negedge wb_clk_in);
		end
	endtask

	function automatic void add_step(input op_e op, input bus_addr_t adr, input byte_sel_t sel,
		input bus_data_t data, input gpio_vec_t pad, input bus_data_t exp);
		step_t s;
		s.op   = op;
		s.adr  = adr;
		s.sel  = sel;
		s.data = data;
		s.pad  = pad;
		s.exp  = exp;
		table_q.push_back(s);
	endfunction

	function automatic void build_table();
		logic [31:0] r1;
		logic [31:0] r2;
		rnd = xorshift32(rnd);
		r1 = rnd;
		rnd = xorshift32(rnd);
		r2 = rnd;

		// full and partial lane writes
		add_step(OP_WR,   A_OUT,   4'hF,    32'hA5A5_5A5A, '0, '0);
		add_step(OP_RD,   A_OUT,   4'hF,    '0, '0, 32'hA5A5_5A5A);
		add_step(OP_PINS, A_OUT,   4'hF,    '0, 32'hA5A5_5A5A, 32'h0000_0000);
		add_step(OP_WR,   A_OUT,   4'b0101, 32'h1122_3344, '0, '0);
		add_step(OP_RD,   A_OUT,   4'hF,    '0, '0, 32'hA522_5A44);
		add_step(OP_WR,   A_OUT,   4'b1000, 32'hFF00_0000, '0, '0);
		add_step(OP_RD,   A_OUT,   4'hF,    '0, '0, 32'hFF22_5A44);
		add_step(OP_WR,   A_OE,    4'hF,    32'h0000_FFFF, '0, '0);
		add_step(OP_WR,   A_OE,    4'b0100, 32'h00CC_0000, '0, '0);
		add_step(OP_RD,   A_OE,    4'hF,    '0, '0, 32'h00CC_FFFF);
		add_step(OP_PINS, A_OE,    4'hF,    '0, 32'hFF22_5A44, 32'h00CC_FFFF);
		add_step(OP_WR,   A_INTE,  4'hF,    32'h1234_5678, '0, '0);
		add_step(OP_WR,   A_INTE,  4'b0010, 32'h0000_AB00, '0, '0);
		add_step(OP_RD,   A_INTE,  4'hF,    '0, '0, 32'h1234_AB78);
		add_step(OP_WR,   A_PTRIG, 4'hF,    32'hFFFF_FFFF, '0, '0);
		add_step(OP_WR,   A_PTRIG, 4'b0011, 32'h0000_0000, '0, '0);
		add_step(OP_RD,   A_PTRIG, 4'hF,    '0, '0, 32'hFFFF_0000);

		// pad input through the synchronizer, offset 7 aliases offset 0
		add_step(OP_PAD,  A_IN,    4'hF,    '0, r1, '0);
		add_step(OP_RD,   A_IN,    4'hF,    '0, '0, r1);
		add_step(OP_RD,   A_ALIAS, 4'hF,    '0, '0, r1);
		add_step(OP_PAD,  A_IN,    4'hF,    '0, r2, '0);
		add_step(OP_RD,   A_IN,    4'hF,    '0, '0, r2);
		add_step(OP_RD,   A_ALIAS, 4'hF,    '0, '0, r2);

		// bad addresses must not touch OUT or OE
		add_step(OP_BAD,  8'h24,   4'hF,    32'hDEAD_BEEF, '0, '0);
		add_step(OP_RD,   A_OUT,   4'hF,    '0, '0, 32'hFF22_5A44);
		add_step(OP_BAD,  8'h88,   4'hF,    32'h0000_0000, '0, '0);
		add_step(OP_RD,   A_OE,    4'hF,    '0, '0, 32'h00CC_FFFF);

		// pins 4,5,9 rising and pin 8 falling enabled, then raise 5, 7 and 8
		add_step(OP_PAD,  A_IN,    4'hF,    '0, 32'h0000_0000, '0);
		add_step(OP_WR,   A_PTRIG, 4'hF,    32'h0000_02F0, '0, '0);
		add_step(OP_WR,   A_INTE,  4'hF,    32'h0000_0330, '0, '0);
		add_step(OP_WR,   A_CTRL,  4'hF,    32'h0000_0001, '0, '0);
		add_step(OP_RD,   A_INTS,  4'hF,    '0, '0, 32'h0000_0000);
		add_step(OP_PAD,  A_IN,    4'hF,    '0, 32'h0000_01A0, '0);
		add_step(OP_INTA, A_IN,    4'hF,    '0, '0, 32'd1);
		add_step(OP_RD,   A_INTS,  4'hF,    '0, '0, 32'h0000_0020);
		add_step(OP_RD,   A_CTRL,  4'hF,    '0, '0, 32'h0000_0003);
		add_step(OP_WR,   A_INTS,  4'hF,    32'h0000_0000, '0, '0);
		add_step(OP_INTA, A_IN,    4'hF,    '0, '0, 32'd0);
		add_step(OP_RD,   A_INTS,  4'hF,    '0, '0, 32'h0000_0000);
	endfunction

	task automatic apply_step(input step_t s);
		logic      ack;
		logic      err;
		bus_data_t rd;
		case (s.op)
			OP_WR:   bus_write(s.adr, s.sel, s.data);
			OP_RD: begin
				bus_read(s.adr, rd);
				check_value($sformatf("wb_dat_o[%h]", s.adr), rd, s.exp);
			end
			OP_BAD: begin
				bus_access(1'b1, s.adr, s.sel, s.data, ack, err, rd);
				check_value("wb_err_o", 32'(err), 32'd1);
				check_value("wb_ack_o", 32'(ack), 32'd0);
			end
			OP_PAD:  hold_pads(s.pad);
			OP_PINS: begin
				@(negedge wb_clk_in);
				check_value("gpio_pad_o", gpio_pad_o, s.pad);
				check_value("gpio_oe_o", gpio_oe_o, s.exp);
			end
			OP_INTA: wait_inta(s.exp[0]);
			default: abort_run("unknown table operation");
		endcase
	endtask

	// replicas must agree on every cycle
	always @(negedge wb_clk_in) begin
		if (!wb_rst_in)
			check_value("tmr_err_o", 32'(tmr_err_o), 32'd0);
	end

	initial begin
		wb_rst_in  = 1'b1;
		wb_cyc_i   = 1'b0;
		wb_stb_i   = 1'b0;
		wb_we_i    = 1'b0;
		wb_adr_i   = '0;
		wb_sel_i   = '0;
		wb_dat_i   = '0;
		gpio_pad_i = '0;
		build_table();

		repeat (4) @(posedge wb_clk_in);
		wb_rst_in <= 1'b0;

		@(negedge wb_clk_in);
		check_value("wb_ack_o", 32'(wb_ack_o), 32'd0);
		check_value("wb_err_o", 32'(wb_err_o), 32'd0);
		check_value("wb_inta_o", 32'(wb_inta_o), 32'd0);
		check_value("gpio_pad_o", gpio_pad_o, 32'd0);
		check_value("gpio_oe_o", gpio_oe_o, 32'd0);
		check_value("tmr_err_o", 32'(tmr_err_o), 32'd0);

		for (int i = 0; i < table_q.size(); i++)
			apply_step(table_q[i]);

		repeat (2) @(posedge wb_clk_in);
		$display("Everything OK");
		$finish;
	end

endmodule

// ==== src/gpio_tmr_top.sv ====
`timescale 1ns/1ps

module gpio_tmr_top import gpio_pkg::*; (
	input  logic      wb_clk_in,
	input  logic      wb_rst_in,
	input  logic      wb_cyc_i,
	input  logic      wb_stb_i,
	input  logic      wb_we_i,
	input  bus_addr_t wb_adr_i,
	input  byte_sel_t wb_sel_i,
	input  bus_data_t wb_dat_i,
	output bus_data_t wb_dat_o,
	output logic      wb_ack_o,
	output logic      wb_err_o,
	output logic      wb_inta_o,
	input  gpio_vec_t gpio_pad_i,
	output gpio_vec_t gpio_pad_o,
	output gpio_vec_t gpio_oe_o,
	output logic      tmr_err_o
);

	gpio_req_if  req ();
	gpio_state_t rep_state [3];
	gpio_state_t voted;

	gpio_bus_decode u_decode (
		.wb_cyc_i (wb_cyc_i),
		.wb_stb_i (wb_stb_i),
		.wb_we_i  (wb_we_i),
		.wb_adr_i (wb_adr_i),
		.wb_sel_i (wb_sel_i),
		.wb_dat_i (wb_dat_i),
		.req      (req)
	);

	// three replicas share the request and the voted state
	for (genvar g = 0; g < 3; g++) begin : g_rep
		gpio_state_core u_core (
			.wb_clk_in  (wb_clk_in),
			.wb_rst_in  (wb_rst_in),
			.req        (req),
			.gpio_pad_i (gpio_pad_i),
			.voted_i    (voted),
			.state_o    (rep_state[g])
		);
	end

	gpio_tmr_voter u_voter (
		.state_a_i  (rep_state[0]),
		.state_b_i  (rep_state[1]),
		.state_c_i  (rep_state[2]),
		.voted_o    (voted),
		.mismatch_o (tmr_err_o)
	);

	assign wb_ack_o   = voted.ack;
	assign wb_err_o   = voted.err;
	assign wb_dat_o   = voted.rdata;
	assign wb_inta_o  = voted.inta;
	assign gpio_pad_o = voted.pad_out;
	assign gpio_oe_o  = voted.oe;

endmodule

// ==== src/gpio_tmr_voter.sv ====
`timescale 1ns/1ps

module gpio_tmr_voter import gpio_pkg::*; (
	input  gpio_state_t state_a_i,
	input  gpio_state_t state_b_i,
	input  gpio_state_t state_c_i,
	output gpio_state_t voted_o,
	output logic        mismatch_o
);

	logic a_bad;
	logic b_bad;
	logic c_bad;

	// bitwise two out of three
	assign voted_o = (state_a_i & state_b_i)
		| (state_a_i & state_c_i)
		| (state_b_i & state_c_i);

	// a replica that lost the vote on any bit
	assign a_bad = (state_a_i != voted_o);
	assign b_bad = (state_b_i != voted_o);
	assign c_bad = (state_c_i != voted_o);

	assign mismatch_o = a_bad | b_bad | c_bad;

	// decoder splits good and bad addresses, so the vote never shows both
	a_ack_err: assert final (!(voted_o.ack && voted_o.err))
		else $error("ack and err voted high together");

endmodule

// ==== src/gpio_state_core.sv ====
`timescale 1ns/1ps

module gpio_state_core import gpio_pkg::*; (
	input  logic        wb_clk_in,
	input  logic        wb_rst_in,
	gpio_req_if.dst     req,
	input  gpio_vec_t   gpio_pad_i,
	input  gpio_state_t voted_i,
	output gpio_state_t state_o
);

	gpio_state_t state_q;
	gpio_state_t nxt;
	logic        wr;
	bus_data_t   rd_mux;
	gpio_vec_t   pin_event;

	// replace only the enabled byte lanes
	function automatic gpio_vec_t lane_merge(
		input gpio_vec_t old_v,
		input bus_data_t data,
		input byte_sel_t be
	);
		gpio_vec_t res;
		res = old_v;
		for (int i = 0; i < SEL_W; i++) begin
			if (be[i])
				res[i*8 +: 8] = data[i*8 +: 8];
		end
		return res;
	endfunction

	assign wr = req.valid & req.addr_ok & req.we;

	// pin moved into in_r this edge and landed on its trigger level
	assign pin_event = (voted_i.sync_b ^ voted_i.in_r) & ~(voted_i.sync_b ^ voted_i.ptrig);

	always_comb begin
		case (req.sel)
			REG_OUT:   rd_mux = voted_i.out;
			REG_OE:    rd_mux = voted_i.oe;
			REG_INTE:  rd_mux = voted_i.inte;
			REG_PTRIG: rd_mux = voted_i.ptrig;
			REG_CTRL:  rd_mux = {{(DATA_W-2){1'b0}}, voted_i.ctrl};
			REG_INTS:  rd_mux = voted_i.ints;
			default:   rd_mux = voted_i.in_r;
		endcase
	end

	always_comb begin
		nxt = voted_i;

		// one-cycle pulses, alternate while stb is held
		nxt.ack = req.valid & req.addr_ok & ~voted_i.ack;
		nxt.err = req.valid & ~req.addr_ok & ~voted_i.err;

		// two-flop synchronizer then input register
		nxt.sync_a = gpio_pad_i;
		nxt.sync_b = voted_i.sync_a;
		nxt.in_r   = voted_i.sync_b;

		nxt.rdata   = rd_mux;
		nxt.pad_out = voted_i.out;
		nxt.inta    = (|voted_i.ints) & voted_i.ctrl[CTRL_INTE];

		if (wr) begin
			case (req.sel)
				REG_OUT:   nxt.out   = lane_merge(voted_i.out, req.wdata, req.be);
				REG_OE:    nxt.oe    = lane_merge(voted_i.oe, req.wdata, req.be);
				REG_INTE:  nxt.inte  = lane_merge(voted_i.inte, req.wdata, req.be);
				REG_PTRIG: nxt.ptrig = lane_merge(voted_i.ptrig, req.wdata, req.be);
				default:   ;
			endcase
		end

		// ctrl takes the whole word, INTS bit latches the interrupt
		if (wr && req.sel == REG_CTRL)
			nxt.ctrl = req.wdata[1:0];
		else if (voted_i.ctrl[CTRL_INTE])
			nxt.ctrl[CTRL_INTS] = voted_i.ctrl[CTRL_INTS] | voted_i.inta;

		if (wr && req.sel == REG_INTS)
			nxt.ints = req.wdata[GPIO_W-1:0];
		else if (voted_i.ctrl[CTRL_INTE])
			nxt.ints = voted_i.ints | (pin_event & voted_i.inte);
	end

	always_ff @(posedge wb_clk_in or posedge wb_rst_in) begin
		if (wb_rst_in)
			state_q <= '0;
		else
			state_q <= nxt;
	end

	assign state_o = state_q;

	// the voted ack is a single-cycle pulse
	a_ack_pulse: assert property (
		@(posedge wb_clk_in) disable iff (wb_rst_in)
		voted_i.ack |=> !voted_i.ack
	) else $error("ack held for two cycles");

endmodule

// ==== src/gpio_bus_decode.sv ====
`timescale 1ns/1ps

module gpio_bus_decode import gpio_pkg::*; (
	input  logic      wb_cyc_i,
	input  logic      wb_stb_i,
	input  logic      wb_we_i,
	input  bus_addr_t wb_adr_i,
	input  byte_sel_t wb_sel_i,
	input  bus_data_t wb_dat_i,
	gpio_req_if.src   req
);

	logic [OFS_MSB-OFS_LSB:0] ofs;
	logic                     upper_zero;
	logic                     lower_zero;

	assign ofs = wb_adr_i[OFS_MSB:OFS_LSB];

	// full decode, nothing above the offset field may be set
	assign upper_zero = (wb_adr_i[ADDR_W-1:OFS_MSB+1] == '0);
	assign lower_zero = (wb_adr_i[OFS_LSB-1:0] == '0);

	assign req.valid   = wb_cyc_i & wb_stb_i;
	assign req.addr_ok = upper_zero & lower_zero;
	assign req.we      = wb_we_i;
	assign req.be      = wb_sel_i;
	assign req.wdata   = wb_dat_i;

	always_comb begin
		case (ofs)
			3'd1:    req.sel = REG_OUT;
			3'd2:    req.sel = REG_OE;
			3'd3:    req.sel = REG_INTE;
			3'd4:    req.sel = REG_PTRIG;
			3'd5:    req.sel = REG_CTRL;
			3'd6:    req.sel = REG_INTS;
			// 0 and 7 both read the input register
			default: req.sel = REG_IN;
		endcase
	end

endmodule

// ==== src/gpio_req_if.sv ====
`timescale 1ns/1ps

interface gpio_req_if import gpio_pkg::*; ();

	// cyc and stb both high
	logic      valid;
	// upper and lower address bits are zero
	logic      addr_ok;
	reg_sel_e  sel;
	logic      we;
	byte_sel_t be;
	bus_data_t wdata;

	modport src (
		output valid, addr_ok, sel, we, be, wdata
	);

	modport dst (
		input valid, addr_ok, sel, we, be, wdata
	);

endinterface

// ==== src/gpio_pkg.sv ====
package gpio_pkg;

	// pin count and bus widths
	localparam int GPIO_W = 32;
	localparam int DATA_W = 32;
	localparam int ADDR_W = 8;
	localparam int SEL_W  = 4;

	// word offset field of the byte address
	localparam int OFS_LSB = 2;
	localparam int OFS_MSB = 4;

	// control register bits
	localparam int CTRL_INTE = 0;
	localparam int CTRL_INTS = 1;

	typedef logic [GPIO_W-1:0] gpio_vec_t;
	typedef logic [DATA_W-1:0] bus_data_t;
	typedef logic [ADDR_W-1:0] bus_addr_t;
	typedef logic [SEL_W-1:0]  byte_sel_t;

	// offset 7 is folded onto REG_IN by the decoder
	typedef enum logic [2:0] {
		REG_IN    = 3'd0,
		REG_OUT   = 3'd1,
		REG_OE    = 3'd2,
		REG_INTE  = 3'd3,
		REG_PTRIG = 3'd4,
		REG_CTRL  = 3'd5,
		REG_INTS  = 3'd6
	} reg_sel_e;

	// full state of one replica, voted bit by bit
	typedef struct packed {
		logic       ack;
		logic       err;
		logic [1:0] ctrl;
		gpio_vec_t  out;
		gpio_vec_t  oe;
		gpio_vec_t  inte;
		gpio_vec_t  ptrig;
		gpio_vec_t  sync_a;
		gpio_vec_t  sync_b;
		gpio_vec_t  in_r;
		gpio_vec_t  ints;
		bus_data_t  rdata;
		logic       inta;
		gpio_vec_t  pad_out;
	} gpio_state_t;

endpackage
